/* common/ahb_mem_pkg.sv */
`default_nettype none

package ahb_mem_pkg;

	typedef logic [31:0] addr_t; // Byte address, or a word index once shifted down.
	typedef logic [31:0] data_t;
	typedef logic [1:0] htrans_t;
	typedef logic [2:0] hsize_t;
	typedef logic [3:0] wait_t; // Wait states a port inserts per active transfer.
	typedef logic [3:0] stall_t;
	typedef logic [3:0] byte_en_t; // One enable per byte lane with lane 0 in bits 7:0.

	localparam htrans_t HTRANS_IDLE = 2'b00;
	localparam htrans_t HTRANS_BUSY = 2'b01;
	localparam htrans_t HTRANS_NONSEQ = 2'b10;
	localparam htrans_t HTRANS_SEQ = 2'b11;

	localparam hsize_t HSIZE_BYTE = 3'b000;
	localparam hsize_t HSIZE_HALF = 3'b001;
	localparam hsize_t HSIZE_WORD = 3'b010;

	// ST_READY also covers the completion cycle of a data phase.
	typedef enum logic [1:0] {
		ST_READY, // Hready high, OKAY response.
		ST_WAIT, // Hready low while wait states run.
		ST_ERROR1, // First ERROR cycle with hready low.
		ST_ERROR2 // Second ERROR cycle with hready high.
	} port_state_t;

endpackage

`default_nettype wire

/* verilog/ahb_wait_config.sv */
`timescale 1ns/100ps
`default_nettype none

module ahb_wait_config
	import ahb_mem_pkg::*;
(
	input wire logic i_clock,
	input wire logic i_reset,
	input wire logic i_cfg_strobe,
	input wire logic i_cfg_port_sel, // Zero selects the instruction port.
	input wire wait_t i_cfg_wait,
	output wait_t o_i_wait,
	output wait_t o_d_wait
);

	wait_t i_wait_q;
	wait_t d_wait_q;

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			i_wait_q <= '0;
			d_wait_q <= '0;
		end else if (i_cfg_strobe) begin
			if (i_cfg_port_sel) begin
				d_wait_q <= i_cfg_wait; // Data port count.
			end else begin
				i_wait_q <= i_cfg_wait; // Instruction port count.
			end
		end
	end

	// The ports sample these on address phase acceptance, one cycle after the strobe.
	assign o_i_wait = i_wait_q;
	assign o_d_wait = d_wait_q;

endmodule

`default_nettype wire

/* ahb_slave/ahb_stall_limiter.sv */
`timescale 1ns/100ps
`default_nettype none

module ahb_stall_limiter
	import ahb_mem_pkg::*;
#(
	parameter int MAX_STALL_LENGTH = 8
) (
	input wire logic i_clock,
	input wire logic i_reset,
	input wire logic i_stall_active,
	output logic o_force_ready
);

	localparam stall_t LAST_STALL = stall_t'(MAX_STALL_LENGTH - 1);

	stall_t count_q; // Stall cycles already seen in the current stall.

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			count_q <= '0;
		end else if (!i_stall_active) begin
			count_q <= '0; // A ready cycle ends the stall.
		end else if (count_q != '1) begin
			count_q <= count_q + 1'b1; // Saturates rather than wrapping.
		end
	end

	// Raised in the last permitted stall cycle so the port leaves its wait
	// state on the next edge, which keeps hready low for at most the bound.
	assign o_force_ready = i_stall_active && (count_q >= LAST_STALL);

endmodule

`default_nettype wire

/* ahb_slave/ahb_slave_port.sv */
`timescale 1ns/100ps
`default_nettype none

module ahb_slave_port
	import ahb_mem_pkg::*;
#(
	parameter int MEM_WORDS = 256,
	parameter int MAX_STALL_LENGTH = 8,
	parameter bit WRITABLE = 1'b1
) (
	input wire logic i_clock,
	input wire logic i_reset,
	input wire addr_t i_haddr,
	input wire htrans_t i_htrans,
	input wire logic i_hwrite,
	input wire hsize_t i_hsize,
	input wire data_t i_hwdata,
	input wire wait_t i_wait,
	input wire data_t i_mem_rdata,
	output logic o_hready,
	output logic o_hresp,
	output data_t o_hrdata,
	output addr_t o_mem_raddr,
	output logic o_mem_we,
	output addr_t o_mem_waddr,
	output byte_en_t o_mem_be,
	output data_t o_mem_wdata
);

	localparam addr_t WORD_LIMIT = addr_t'(MEM_WORDS);

	port_state_t state_q;
	port_state_t state_d;
	wait_t wait_q; // Wait states still to run.
	wait_t wait_d;
	logic xfer_ok_q; // A legal active transfer is in its data phase.
	addr_t addr_q;
	hsize_t size_q;
	logic write_q;
	logic active;
	logic illegal;
	logic complete;
	logic force_ready;
	addr_t word_idx_q;

	assign active = (i_htrans == HTRANS_NONSEQ) || (i_htrans == HTRANS_SEQ);
	assign illegal = ({2'b00, i_haddr[31:2]} >= WORD_LIMIT) || (i_hwrite && !WRITABLE);

	always_comb begin
		state_d = state_q;
		wait_d = wait_q;
		case (state_q)
			ST_READY, ST_ERROR2: begin
				state_d = ST_READY; // IDLE and BUSY data phases need no waits.
				if (active && illegal) begin
					state_d = ST_ERROR1; // Errors skip the wait states.
				end else if (active && (i_wait != '0)) begin
					state_d = ST_WAIT;
					wait_d = i_wait;
				end
			end
			ST_WAIT: begin
				if (force_ready || (wait_q == wait_t'(1))) begin
					state_d = ST_READY;
				end else begin
					wait_d = wait_q - 1'b1;
				end
			end
			ST_ERROR1: state_d = ST_ERROR2;
			default: state_d = ST_READY;
		endcase
	end

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state_q <= ST_READY;
			wait_q <= '0;
			xfer_ok_q <= 1'b0;
		end else begin
			state_q <= state_d;
			wait_q <= wait_d;
			if (o_hready) begin
				xfer_ok_q <= active && !illegal; // New address phase accepted.
			end
		end
	end

	always_ff @(posedge i_clock) begin
		if (o_hready) begin
			addr_q <= i_haddr;
			size_q <= i_hsize;
			write_q <= i_hwrite;
		end
	end

	ahb_stall_limiter #(
		.MAX_STALL_LENGTH(MAX_STALL_LENGTH)
	) stall_limiter0 (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_stall_active(state_q == ST_WAIT),
		.o_force_ready(force_ready)
	);

	assign o_hready = (state_q != ST_WAIT) && (state_q != ST_ERROR1);
	assign o_hresp = (state_q == ST_ERROR1) || (state_q == ST_ERROR2);

	// The data phase of a legal transfer ends in its first ready cycle.
	assign complete = xfer_ok_q && (state_q == ST_READY);

	assign word_idx_q = {2'b00, addr_q[31:2]};
	assign o_mem_raddr = word_idx_q;
	assign o_hrdata = (complete && !write_q) ? i_mem_rdata : '0;

	always_comb begin
		case (size_q)
			HSIZE_BYTE: o_mem_be = byte_en_t'(4'b0001 << addr_q[1:0]);
			HSIZE_HALF: o_mem_be = addr_q[1] ? 4'b1100 : 4'b0011;
			HSIZE_WORD: o_mem_be = 4'b1111;
			default: o_mem_be = 4'b1111; // Larger sizes are treated as a word.
		endcase
	end

	assign o_mem_we = complete && write_q;
	assign o_mem_waddr = word_idx_q;
	assign o_mem_wdata = i_hwdata; // Write data arrives lane-aligned in the data phase.

endmodule

`default_nettype wire

/* verilog/shared_word_memory.sv */
`timescale 1ns/100ps
`default_nettype none

module shared_word_memory
	import ahb_mem_pkg::*;
#(
	parameter int MEM_WORDS = 256
) (
	input wire logic i_clock,
	input wire addr_t i_i_raddr,
	input wire addr_t i_d_raddr,
	input wire logic i_we,
	input wire addr_t i_waddr,
	input wire byte_en_t i_be,
	input wire data_t i_wdata,
	output data_t o_i_rdata,
	output data_t o_d_rdata
);

	localparam int IDX_W = $clog2(MEM_WORDS);

	data_t mem [MEM_WORDS];

	// Reads see the array before this cycle's write lands.
	assign o_i_rdata = mem[i_i_raddr[IDX_W-1:0]];
	assign o_d_rdata = mem[i_d_raddr[IDX_W-1:0]];

	always_ff @(posedge i_clock) begin
		if (i_we) begin
			for (int b = 0; b < 4; b++) begin
				if (i_be[b]) begin
					mem[i_waddr[IDX_W-1:0]][b*8 +: 8] <= i_wdata[b*8 +: 8];
				end
			end
		end
	end

endmodule

`default_nettype wire

/* verilog/ahb_dual_port_memory.sv */
`timescale 1ns/100ps
`default_nettype none

module ahb_dual_port_memory
	import ahb_mem_pkg::*;
#(
	parameter int MEM_WORDS = 256,
	parameter int MAX_STALL_LENGTH = 8
) (
	input wire logic i_clock,
	input wire logic i_reset,
	input wire addr_t i_i_haddr,
	input wire htrans_t i_i_htrans,
	input wire logic i_i_hwrite,
	input wire hsize_t i_i_hsize,
	input wire data_t i_i_hwdata,
	output logic o_i_hready,
	output logic o_i_hresp,
	output data_t o_i_hrdata,
	input wire addr_t i_d_haddr,
	input wire htrans_t i_d_htrans,
	input wire logic i_d_hwrite,
	input wire hsize_t i_d_hsize,
	input wire data_t i_d_hwdata,
	output logic o_d_hready,
	output logic o_d_hresp,
	output data_t o_d_hrdata,
	input wire logic i_cfg_strobe,
	input wire logic i_cfg_port_sel,
	input wire wait_t i_cfg_wait
);

	wait_t instr_wait;
	wait_t data_wait;
	addr_t instr_raddr;
	data_t instr_rdata;
	addr_t data_raddr;
	data_t data_rdata;
	logic data_we;
	addr_t data_waddr;
	byte_en_t data_be;
	data_t data_wdata;

	ahb_wait_config cfg0 (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_cfg_strobe(i_cfg_strobe),
		.i_cfg_port_sel(i_cfg_port_sel),
		.i_cfg_wait(i_cfg_wait),
		.o_i_wait(instr_wait),
		.o_d_wait(data_wait)
	);

	// The instruction port is read-only, so its write side stays open.
	ahb_slave_port #(
		.MEM_WORDS(MEM_WORDS),
		.MAX_STALL_LENGTH(MAX_STALL_LENGTH),
		.WRITABLE(1'b0)
	) instr_port0 (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_haddr(i_i_haddr),
		.i_htrans(i_i_htrans),
		.i_hwrite(i_i_hwrite),
		.i_hsize(i_i_hsize),
		.i_hwdata(i_i_hwdata),
		.i_wait(instr_wait),
		.i_mem_rdata(instr_rdata),
		.o_hready(o_i_hready),
		.o_hresp(o_i_hresp),
		.o_hrdata(o_i_hrdata),
		.o_mem_raddr(instr_raddr),
		.o_mem_we(),
		.o_mem_waddr(),
		.o_mem_be(),
		.o_mem_wdata()
	);

	ahb_slave_port #(
		.MEM_WORDS(MEM_WORDS),
		.MAX_STALL_LENGTH(MAX_STALL_LENGTH),
		.WRITABLE(1'b1)
	) data_port0 (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_haddr(i_d_haddr),
		.i_htrans(i_d_htrans),
		.i_hwrite(i_d_hwrite),
		.i_hsize(i_d_hsize),
		.i_hwdata(i_d_hwdata),
		.i_wait(data_wait),
		.i_mem_rdata(data_rdata),
		.o_hready(o_d_hready),
		.o_hresp(o_d_hresp),
		.o_hrdata(o_d_hrdata),
		.o_mem_raddr(data_raddr),
		.o_mem_we(data_we),
		.o_mem_waddr(data_waddr),
		.o_mem_be(data_be),
		.o_mem_wdata(data_wdata)
	);

	shared_word_memory #(
		.MEM_WORDS(MEM_WORDS)
	) mem0 (
		.i_clock(i_clock),
		.i_i_raddr(instr_raddr),
		.i_d_raddr(data_raddr),
		.i_we(data_we),
		.i_waddr(data_waddr),
		.i_be(data_be),
		.i_wdata(data_wdata),
		.o_i_rdata(instr_rdata),
		.o_d_rdata(data_rdata)
	);

endmodule

`default_nettype wire

/* tb/ahb_dual_port_memory_properties.sv */
`timescale 1ns/100ps
`default_nettype none

module ahb_dual_port_memory_properties
	import ahb_mem_pkg::*;
#(
	parameter int MAX_STALL_LENGTH = 8
) (
	input wire logic i_clock,
	input wire logic i_reset,
	input wire htrans_t i_htrans,
	input wire logic i_hready,
	input wire logic i_hresp,
	input wire logic i_mem_we
);

	int error_count = 0; // Bus rule violations seen on this port.

	idle_no_wait: assert property (@(posedge i_clock) disable iff (i_reset)
		(i_hready && (i_htrans == HTRANS_IDLE)) |=> i_hready)
		else begin
			error_count++;
			$error("Data phase after an IDLE transfer was stalled.");
		end

	// Hready must come back within the bound once it drops.
	stall_bound: assert property (@(posedge i_clock) disable iff (i_reset)
		$fell(i_hready) |-> ##[1:MAX_STALL_LENGTH] i_hready)
		else begin
			error_count++;
			$error("Hready stayed low longer than the stall bound.");
		end

	error_two_cycles: assert property (@(posedge i_clock) disable iff (i_reset)
		(i_hresp && !i_hready) |=> (i_hresp && i_hready))
		else begin
			error_count++;
			$error("First ERROR cycle not followed by the second one.");
		end

	no_write_in_stall: assert property (@(posedge i_clock) disable iff (i_reset)
		!i_hready |-> !i_mem_we)
		else begin
			error_count++;
			$error("Memory write while hready was low.");
		end

endmodule

bind ahb_slave_port ahb_dual_port_memory_properties #(
	.MAX_STALL_LENGTH(MAX_STALL_LENGTH)
) props0 (
	.i_clock(i_clock),
	.i_reset(i_reset),
	.i_htrans(i_htrans),
	.i_hready(o_hready),
	.i_hresp(o_hresp),
	.i_mem_we(o_mem_we)
);

`default_nettype wire

/* tb/ahb_dual_port_memory_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module ahb_dual_port_memory_tb
	import ahb_mem_pkg::*;
();

	localparam int MEM_WORDS = 256;
	localparam int MAX_STALL_LENGTH = 8;
	localparam int RESET_CYCLES = 16;
	localparam int TIMEOUT_MARGIN = 100;
	localparam logic I_PORT = 1'b0;
	localparam logic D_PORT = 1'b1;

	typedef struct packed {
		logic port;
		wait_t wait_cnt;
		logic write;
		addr_t addr;
		hsize_t size;
		data_t wdata;
		data_t rdata; // Only compared on reads that end with OKAY.
		logic resp;
		stall_t stall;
	} entry_t;

	logic clock;
	logic reset;
	addr_t i_i_haddr;
	htrans_t i_i_htrans;
	logic i_i_hwrite;
	hsize_t i_i_hsize;
	data_t i_i_hwdata;
	logic o_i_hready;
	logic o_i_hresp;
	data_t o_i_hrdata;
	addr_t i_d_haddr;
	htrans_t i_d_htrans;
	logic i_d_hwrite;
	hsize_t i_d_hsize;
	data_t i_d_hwdata;
	logic o_d_hready;
	logic o_d_hresp;
	data_t o_d_hrdata;
	logic i_cfg_strobe;
	logic i_cfg_port_sel;
	wait_t i_cfg_wait;

	entry_t tests[$];
	wait_t cur_wait[2];
	integer seed = 32'h6731_4403;
	int cycle_count = 0;

	ahb_dual_port_memory #(
		.MEM_WORDS(MEM_WORDS),
		.MAX_STALL_LENGTH(MAX_STALL_LENGTH)
	) dut0 (
		.i_clock(clock),
		.i_reset(reset),
		.*
	);

	initial begin
		clock = 1'b0;
		forever begin
			#4 clock = ~clock;
		end
	end

	// Each entry needs at most a config write, an address phase, the full stall and completion.
	always @(posedge clock) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count > tests.size() * (MAX_STALL_LENGTH + 4) + RESET_CYCLES
				+ TIMEOUT_MARGIN) begin
			$display("Timeout: the DUT did not finish the transfers in time.");
			$display("SOME TESTS FAILED");
			$fatal(1, "Run stopped by the cycle limit.");
		end
	end

	task automatic stop_run();
		$display("SOME TESTS FAILED");
		$fatal(1, "Run stopped at the first error.");
	endtask

	task automatic check_data(input string name, input data_t expected, input data_t actual);
		if (actual !== expected) begin
			$display("FAIL at %0t: %s expected %h, got %h", $time, name, expected, actual);
			stop_run();
		end
	endtask

	task automatic check_resp(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			$display("FAIL at %0t: %s expected %b, got %b", $time, name, expected, actual);
			stop_run();
		end
	endtask

	task automatic check_stall(input string name, input stall_t expected, input stall_t actual);
		if (actual !== expected) begin
			$display("FAIL at %0t: %s expected %0d, got %0d", $time, name, expected, actual);
			stop_run();
		end
	endtask

	task automatic add_entry(input logic port, input wait_t w, input logic write,
			input addr_t addr, input hsize_t size, input data_t wdata, input data_t rdata,
			input logic resp, input stall_t stall);
		tests.push_back('{port, w, write, addr, size, wdata, rdata, resp, stall});
	endtask

	task automatic drive_bus(input logic port, input htrans_t trans, input logic write,
			input addr_t addr, input hsize_t size, input data_t wdata);
		if (port) begin
			i_d_htrans <= trans;
			i_d_hwrite <= write;
			i_d_haddr <= addr;
			i_d_hsize <= size;
			i_d_hwdata <= wdata;
		end else begin
			i_i_htrans <= trans;
			i_i_hwrite <= write;
			i_i_haddr <= addr;
			i_i_hsize <= size;
			i_i_hwdata <= wdata;
		end
	endtask

	// Single-cycle strobe that returns on the edge which loads the register.
	task automatic set_wait(input logic port, input wait_t value);
		@(posedge clock);
		i_cfg_strobe <= 1'b1;
		i_cfg_port_sel <= port;
		i_cfg_wait <= value;
		@(posedge clock);
		i_cfg_strobe <= 1'b0;
		cur_wait[port] = value;
	endtask

	task automatic run_transfer(input entry_t e);
		int stall;
		logic ready;
		logic resp;
		data_t rdata;
		stall = 0;
		@(posedge clock);
		drive_bus(e.port, HTRANS_NONSEQ, e.write, e.addr, e.size, e.wdata);
		@(posedge clock);
		drive_bus(e.port, HTRANS_IDLE, 1'b0, '0, HSIZE_WORD, e.wdata); // Data phase starts.
		do begin
			@(negedge clock);
			ready = e.port ? o_d_hready : o_i_hready;
			if (!ready) begin
				stall++;
			end
		end while (!ready);
		resp = e.port ? o_d_hresp : o_i_hresp;
		rdata = e.port ? o_d_hrdata : o_i_hrdata;
		check_resp(e.port ? "o_d_hresp" : "o_i_hresp", e.resp, resp);
		check_stall(e.port ? "o_d_hready low cycles" : "o_i_hready low cycles", e.stall,
			stall_t'(stall));
		if (!e.write && !e.resp) begin
			check_data(e.port ? "o_d_hrdata" : "o_i_hrdata", e.rdata, rdata);
		end
	endtask

	initial begin
		data_t rnd[3];
		reset = 1'b1;
		i_cfg_strobe = 1'b0;
		i_cfg_port_sel = 1'b0;
		i_cfg_wait = '0;
		cur_wait = '{default: '0};
		drive_bus(I_PORT, HTRANS_IDLE, 1'b0, '0, HSIZE_WORD, '0);
		drive_bus(D_PORT, HTRANS_IDLE, 1'b0, '0, HSIZE_WORD, '0);
		for (int k = 0; k < 3; k++) begin
			rnd[k] = $random(seed);
		end
		// Word writes and read-back on both ports.
		add_entry(D_PORT, 0, 1, 32'h000, HSIZE_WORD, rnd[0], '0, 0, 0);
		add_entry(D_PORT, 0, 1, 32'h004, HSIZE_WORD, rnd[1], '0, 0, 0);
		add_entry(D_PORT, 0, 1, 32'h3FC, HSIZE_WORD, rnd[2], '0, 0, 0);
		add_entry(D_PORT, 0, 0, 32'h000, HSIZE_WORD, '0, rnd[0], 0, 0);
		add_entry(D_PORT, 0, 0, 32'h004, HSIZE_WORD, '0, rnd[1], 0, 0);
		add_entry(D_PORT, 0, 0, 32'h3FC, HSIZE_WORD, '0, rnd[2], 0, 0);
		add_entry(I_PORT, 0, 0, 32'h000, HSIZE_WORD, '0, rnd[0], 0, 0);
		add_entry(I_PORT, 0, 0, 32'h3FC, HSIZE_WORD, '0, rnd[2], 0, 0);
		// Lane merging. Unused lanes carry junk that must not land.
		add_entry(D_PORT, 0, 1, 32'h040, HSIZE_WORD, 32'h1122_3344, '0, 0, 0);
		add_entry(D_PORT, 0, 1, 32'h041, HSIZE_BYTE, 32'h5566_AA77, '0, 0, 0);
		add_entry(D_PORT, 0, 1, 32'h042, HSIZE_HALF, 32'hBEEF_1234, '0, 0, 0);
		add_entry(D_PORT, 0, 1, 32'h040, HSIZE_BYTE, 32'h0000_00CC, '0, 0, 0);
		add_entry(D_PORT, 0, 0, 32'h040, HSIZE_WORD, '0, 32'hBEEF_AACC, 0, 0);
		add_entry(D_PORT, 0, 1, 32'h050, HSIZE_WORD, 32'hA5A5_A5A5, '0, 0, 0);
		add_entry(D_PORT, 0, 1, 32'h050, HSIZE_HALF, 32'h7788_9900, '0, 0, 0);
		add_entry(D_PORT, 0, 1, 32'h052, HSIZE_BYTE, 32'h115A_2233, '0, 0, 0);
		add_entry(D_PORT, 0, 0, 32'h050, HSIZE_WORD, '0, 32'hA55A_9900, 0, 0);
		// Wait states. A count of 15 is capped at the stall bound.
		add_entry(D_PORT, 3, 0, 32'h040, HSIZE_WORD, '0, 32'hBEEF_AACC, 0, 3);
		add_entry(D_PORT, 7, 1, 32'h008, HSIZE_WORD, 32'h0BAD_F00D, '0, 0, 7);
		add_entry(I_PORT, 15, 0, 32'h008, HSIZE_WORD, '0, 32'h0BAD_F00D, 0, 8);
		add_entry(D_PORT, 7, 0, 32'h004, HSIZE_WORD, '0, rnd[1], 0, 7);
		add_entry(I_PORT, 3, 0, 32'h040, HSIZE_WORD, '0, 32'hBEEF_AACC, 0, 3);
		add_entry(D_PORT, 15, 0, 32'h008, HSIZE_WORD, '0, 32'h0BAD_F00D, 0, 8);
		add_entry(I_PORT, 0, 0, 32'h004, HSIZE_WORD, '0, rnd[1], 0, 0);
		// Errors. Address 0x400 would alias word 0 if it reached the array.
		add_entry(D_PORT, 0, 1, 32'h400, HSIZE_WORD, 32'hFFFF_FFFF, '0, 1, 1);
		add_entry(D_PORT, 0, 0, 32'h000, HSIZE_WORD, '0, rnd[0], 0, 0);
		add_entry(D_PORT, 3, 0, 32'h7FC, HSIZE_WORD, '0, '0, 1, 1);
		add_entry(I_PORT, 0, 1, 32'h040, HSIZE_WORD, 32'hDEAD_BEEF, '0, 1, 1);
		add_entry(D_PORT, 0, 0, 32'h040, HSIZE_WORD, '0, 32'hBEEF_AACC, 0, 0);

		repeat (RESET_CYCLES) @(posedge clock);
		reset <= 1'b0;
		@(negedge clock);
		check_resp("o_i_hready", 1'b1, o_i_hready);
		check_resp("o_i_hresp", 1'b0, o_i_hresp);
		check_data("o_i_hrdata", '0, o_i_hrdata);
		check_resp("o_d_hready", 1'b1, o_d_hready);
		check_resp("o_d_hresp", 1'b0, o_d_hresp);
		check_data("o_d_hrdata", '0, o_d_hrdata);

		// IDLE transfers complete at once even with waits configured.
		set_wait(I_PORT, 7);
		set_wait(D_PORT, 7);
		drive_bus(I_PORT, HTRANS_IDLE, 1'b0, 32'h010, HSIZE_WORD, '0);
		drive_bus(D_PORT, HTRANS_IDLE, 1'b0, 32'h010, HSIZE_WORD, '0);
		repeat (2) begin
			@(negedge clock);
			check_resp("o_i_hready", 1'b1, o_i_hready);
			check_resp("o_i_hresp", 1'b0, o_i_hresp);
			check_resp("o_d_hready", 1'b1, o_d_hready);
			check_resp("o_d_hresp", 1'b0, o_d_hresp);
		end

		foreach (tests[k]) begin
			if (tests[k].wait_cnt != cur_wait[tests[k].port]) begin
				set_wait(tests[k].port, tests[k].wait_cnt);
			end
			run_transfer(tests[k]);
		end

		repeat (2) @(posedge clock);
		if (dut0.instr_port0.props0.error_count == 0 &&
				dut0.data_port0.props0.error_count == 0) begin
			$display("ALL TESTS PASSED");
			$finish;
		end else begin
			$display("A bus rule assertion failed during the run.");
			$display("SOME TESTS FAILED");
			$fatal(1, "Assertion failures seen.");
		end
	end

endmodule

`default_nettype wire

/* sources.f */
common/ahb_mem_pkg.sv
verilog/ahb_wait_config.sv
ahb_slave/ahb_stall_limiter.sv
ahb_slave/ahb_slave_port.sv
verilog/shared_word_memory.sv
verilog/ahb_dual_port_memory.sv
tb/ahb_dual_port_memory_properties.sv
tb/ahb_dual_port_memory_tb.sv
